// ==== src.f ====
+incdir+include
hdl/regfile_pkg.sv
hdl/gpr_array.sv
hdl/operand_bypass.sv
hdl/hazard_ctrl.sv
hdl/id_operand_unit.sv
sim/tb_id_operand_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_id_operand_unit -o sim_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "NO ERRORS"; then
    exit 0
else
    echo "simulation did not report a clean run"
    exit 1
fi

// ==== include/rf_model.svh ====
`ifndef RF_MODEL_SVH
`define RF_MODEL_SVH

// reference copy of the register file and branch bypass registers
logic [DATA_W-1:0] m_regs [NUM_REGS];
logic              m_as1;
logic              m_as2;
logic [DATA_W-1:0] m_ex_data;

function automatic bit m_writes(wr_port_t wr, logic [ADDR_W-1:0] addr);
    return (|wr.wen) && (wr.waddr == addr);
endfunction

function automatic bit m_hit(rd_req_t rd, wr_port_t wr);
    return rd.ren && (rd.raddr != '0) && m_writes(wr, rd.raddr);
endfunction

// use_ex clear gives the raw operand
function automatic logic [DATA_W-1:0] m_operand(rd_req_t rd, wr_port_t wb, wr_port_t mem,
                                                wr_port_t ex, bit use_ex);
    logic [DATA_W-1:0] word;
    word = m_regs[rd.raddr];
    if (use_ex && rd.raddr == '0) return '0;
    if (use_ex && m_writes(ex, rd.raddr)) return ex.wdata;
    if (m_writes(mem, rd.raddr)) return mem.wdata;
    for (int b = 0; b < NUM_BYTES; b++) begin
        if (wb.waddr == rd.raddr && wb.wen[b]) word[8*b +: 8] = wb.wdata[8*b +: 8];
    end
    return word;
endfunction

function automatic bit m_stall(rd_req_t rd1, rd_req_t rd2, wr_port_t ex, wr_port_t mem,
                               bit ex_nofwd, bit mem_nofwd, bit br);
    bit ex_hit;
    bit mem_hit;
    ex_hit  = m_hit(rd1, ex) || m_hit(rd2, ex);
    mem_hit = m_hit(rd1, mem) || m_hit(rd2, mem);
    return (ex_hit && (ex_nofwd || br)) || (mem_hit && mem_nofwd);
endfunction

function automatic void m_reset();
    for (int r = 0; r < NUM_REGS; r++) m_regs[r] = '0;
    m_as1     = 1'b0;
    m_as2     = 1'b0;
    m_ex_data = '0;
endfunction

// state update at a rising edge, from the inputs seen before it
function automatic void m_clock(rd_req_t rd1, rd_req_t rd2, wr_port_t wb, wr_port_t ex, bit br);
    for (int b = 0; b < NUM_BYTES; b++) begin
        if (wb.wen[b]) m_regs[wb.waddr][8*b +: 8] = wb.wdata[8*b +: 8];
    end
    m_as1     = m_hit(rd1, ex) && br;
    m_as2     = m_hit(rd2, ex) && br;
    m_ex_data = ex.wdata;
endfunction

`endif

// ==== sim/tb_id_operand_unit.sv ====
`timescale 1ns/1ps

module tb_id_operand_unit
    import regfile_pkg::*;
();

    localparam int NUM_CYCLES    = 4000;
    localparam int RESET_TIMEOUT = 50;
    localparam int RUN_TIMEOUT   = NUM_CYCLES + NUM_REGS + 200;

    logic              clk;
    logic              arst_n_i;
    rd_req_t           rd1;
    rd_req_t           rd2;
    wr_port_t          wb_wr;
    wr_port_t          ex_wr;
    wr_port_t          mem_wr;
    logic              ex_nofwd;
    logic              mem_nofwd;
    logic              id_is_branch;
    logic [DATA_W-1:0] rdata1;
    logic [DATA_W-1:0] rdata2;
    logic [DATA_W-1:0] raw_data1;
    logic [DATA_W-1:0] raw_data2;
    logic              stall;
    logic [DATA_W-1:0] ex_data_to_id;
    logic              ex_res_as1;
    logic              ex_res_as2;

    integer seed = 32'h294861f8;
    int     checks;
    int     mismatches;
    int     timeouts;
    logic   stim_done;

    `include "rf_model.svh"

    id_operand_unit i_id_operand_unit (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .rd1_i           (rd1),
        .rd2_i           (rd2),
        .wb_wr_i         (wb_wr),
        .ex_wr_i         (ex_wr),
        .mem_wr_i        (mem_wr),
        .ex_nofwd_i      (ex_nofwd),
        .mem_nofwd_i     (mem_nofwd),
        .id_is_branch_i  (id_is_branch),
        .rdata1_o        (rdata1),
        .rdata2_o        (rdata2),
        .raw_data1_o     (raw_data1),
        .raw_data2_o     (raw_data2),
        .stall_o         (stall),
        .ex_data_to_id_o (ex_data_to_id),
        .ex_res_as1_o    (ex_res_as1),
        .ex_res_as2_o    (ex_res_as2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for five rising edges
    initial begin
        arst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n_i = 1'b1;
    end

    task automatic check_word(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        check_word("rdata1_o", rdata1, m_operand(rd1, wb_wr, mem_wr, ex_wr, 1'b1));
        check_word("rdata2_o", rdata2, m_operand(rd2, wb_wr, mem_wr, ex_wr, 1'b1));
        check_word("raw_data1_o", raw_data1, m_operand(rd1, wb_wr, mem_wr, ex_wr, 1'b0));
        check_word("raw_data2_o", raw_data2, m_operand(rd2, wb_wr, mem_wr, ex_wr, 1'b0));
        check_bit("stall_o", stall,
                  m_stall(rd1, rd2, ex_wr, mem_wr, ex_nofwd, mem_nofwd, id_is_branch));
        check_bit("ex_res_as1_o", ex_res_as1, m_as1);
        check_bit("ex_res_as2_o", ex_res_as2, m_as2);
        check_word("ex_data_to_id_o", ex_data_to_id, m_ex_data);
    endtask

    // outputs compared mid-cycle, model advanced with the pre-edge inputs
    task automatic step_and_check();
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        m_clock(rd1, rd2, wb_wr, ex_wr, id_is_branch);
        #1;
    endtask

    task automatic random_write(output wr_port_t wr);
        logic [31:0] r;
        r         = $random(seed);
        wr.wen    = r[0] ? r[4:1] : 4'h0;
        wr.waddr  = {2'b00, r[7:5]};
        wr.wdata  = $random(seed);
    endtask

    // small address range keeps hazards frequent
    task automatic drive_random();
        logic [31:0] r;
        r            = $random(seed);
        rd1.ren      = r[0];
        rd1.raddr    = {2'b00, r[3:1]};
        rd2.ren      = r[4];
        rd2.raddr    = {2'b00, r[7:5]};
        ex_nofwd     = (r[9:8] == 2'b00);
        mem_nofwd    = (r[11:10] == 2'b00);
        id_is_branch = (r[13:12] == 2'b00);
        random_write(wb_wr);
        random_write(ex_wr);
        random_write(mem_wr);
    endtask

    task automatic run_stimulus();
        #1;
        // every register reads zero right after reset
        for (int a = 0; a < NUM_REGS; a++) begin
            rd1.ren   = 1'b1;
            rd1.raddr = ADDR_W'(a);
            rd2.ren   = 1'b1;
            rd2.raddr = ADDR_W'(NUM_REGS - 1 - a);
            step_and_check();
        end
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random();
            step_and_check();
        end
        stim_done = 1'b1;
    endtask

    initial begin
        int wait_cnt;
        checks       = 0;
        mismatches   = 0;
        timeouts     = 0;
        stim_done    = 1'b0;
        rd1          = '0;
        rd2          = '0;
        wb_wr        = '0;
        ex_wr        = '0;
        mem_wr       = '0;
        ex_nofwd     = 1'b0;
        mem_nofwd    = 1'b0;
        id_is_branch = 1'b0;
        m_reset();

        wait_cnt = 0;
        while (arst_n_i !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (arst_n_i !== 1'b1) begin
            timeouts++;
            $display("timeout: reset was never released");
        end else begin
            fork
                run_stimulus();
            join_none
            wait_cnt = 0;
            while (!stim_done && wait_cnt < RUN_TIMEOUT) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (!stim_done) begin
                timeouts++;
                $display("timeout: random stimulus did not finish in time");
            end
        end

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== hdl/id_operand_unit.sv ====
`timescale 1ns/1ps

module id_operand_unit
    import regfile_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  rd_req_t           rd1_i,
    input  rd_req_t           rd2_i,
    input  wr_port_t          wb_wr_i,
    input  wr_port_t          ex_wr_i,
    input  wr_port_t          mem_wr_i,
    input  logic              ex_nofwd_i,
    input  logic              mem_nofwd_i,
    input  logic              id_is_branch_i,
    output logic [DATA_W-1:0] rdata1_o,
    output logic [DATA_W-1:0] rdata2_o,
    output logic [DATA_W-1:0] raw_data1_o,
    output logic [DATA_W-1:0] raw_data2_o,
    output logic              stall_o,
    output logic [DATA_W-1:0] ex_data_to_id_o,
    output logic              ex_res_as1_o,
    output logic              ex_res_as2_o
);

    logic [DATA_W-1:0] arr_data1;
    logic [DATA_W-1:0] arr_data2;
    logic              ex_hit1;
    logic              ex_hit2;
    logic              mem_hit1;
    logic              mem_hit2;

    gpr_array i_gpr_array (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wb_wr_i     (wb_wr_i),
        .raddr1_i    (rd1_i.raddr),
        .raddr2_i    (rd2_i.raddr),
        .arr_data1_o (arr_data1),
        .arr_data2_o (arr_data2)
    );

    // one bypass mux per read port
    operand_bypass i_bypass1 (
        .rd_i          (rd1_i),
        .arr_data_i    (arr_data1),
        .wb_wr_i       (wb_wr_i),
        .mem_wr_i      (mem_wr_i),
        .ex_wr_i       (ex_wr_i),
        .operand_o     (rdata1_o),
        .raw_operand_o (raw_data1_o),
        .ex_hit_o      (ex_hit1),
        .mem_hit_o     (mem_hit1)
    );

    operand_bypass i_bypass2 (
        .rd_i          (rd2_i),
        .arr_data_i    (arr_data2),
        .wb_wr_i       (wb_wr_i),
        .mem_wr_i      (mem_wr_i),
        .ex_wr_i       (ex_wr_i),
        .operand_o     (rdata2_o),
        .raw_operand_o (raw_data2_o),
        .ex_hit_o      (ex_hit2),
        .mem_hit_o     (mem_hit2)
    );

    hazard_ctrl i_hazard_ctrl (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .ex_hit1_i       (ex_hit1),
        .ex_hit2_i       (ex_hit2),
        .mem_hit1_i      (mem_hit1),
        .mem_hit2_i      (mem_hit2),
        .ex_nofwd_i      (ex_nofwd_i),
        .mem_nofwd_i     (mem_nofwd_i),
        .id_is_branch_i  (id_is_branch_i),
        .ex_wdata_i      (ex_wr_i.wdata),
        .stall_o         (stall_o),
        .ex_res_as1_o    (ex_res_as1_o),
        .ex_res_as2_o    (ex_res_as2_o),
        .ex_data_to_id_o (ex_data_to_id_o)
    );

endmodule

// ==== hdl/hazard_ctrl.sv ====
`timescale 1ns/1ps

module hazard_ctrl
    import regfile_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              ex_hit1_i,
    input  logic              ex_hit2_i,
    input  logic              mem_hit1_i,
    input  logic              mem_hit2_i,
    input  logic              ex_nofwd_i,
    input  logic              mem_nofwd_i,
    input  logic              id_is_branch_i,
    input  logic [DATA_W-1:0] ex_wdata_i,
    output logic              stall_o,
    output logic              ex_res_as1_o,
    output logic              ex_res_as2_o,
    output logic [DATA_W-1:0] ex_data_to_id_o
);

    logic ex_hit;
    logic mem_hit;
    logic load_use_stall;
    logic mem_wait_stall;
    logic branch_stall;

    assign ex_hit  = ex_hit1_i || ex_hit2_i;
    assign mem_hit = mem_hit1_i || mem_hit2_i;

    // result not ready in ex or mem yet
    assign load_use_stall = ex_hit && ex_nofwd_i;
    assign mem_wait_stall = mem_hit && mem_nofwd_i;

    // branch compares resolve in ID, so an ex result costs one cycle
    assign branch_stall = ex_hit && id_is_branch_i;

    assign stall_o = load_use_stall || mem_wait_stall || branch_stall;

    // ex result and per-operand select handed to the branch next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_res_as1_o    <= 1'b0;
            ex_res_as2_o    <= 1'b0;
            ex_data_to_id_o <= '0;
        end else begin
            ex_res_as1_o    <= ex_hit1_i && id_is_branch_i;
            ex_res_as2_o    <= ex_hit2_i && id_is_branch_i;
            ex_data_to_id_o <= ex_wdata_i;
        end
    end

    // a bypass flag always follows a branch stall cycle
    property p_as_after_stall;
        @(posedge clk) disable iff (!arst_n_i)
            (ex_res_as1_o || ex_res_as2_o) |-> $past(stall_o);
    endproperty

    a_as_after_stall: assert property (p_as_after_stall)
        else $error("hazard_ctrl: branch bypass flag without prior stall");

endmodule

// ==== hdl/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass
    import regfile_pkg::*;
(
    input  rd_req_t           rd_i,
    input  logic [DATA_W-1:0] arr_data_i,
    input  wr_port_t          wb_wr_i,
    input  wr_port_t          mem_wr_i,
    input  wr_port_t          ex_wr_i,
    output logic [DATA_W-1:0] operand_o,
    output logic [DATA_W-1:0] raw_operand_o,
    output logic              ex_hit_o,
    output logic              mem_hit_o
);

    logic              ex_match;
    logic              mem_match;
    logic              wb_match;
    logic              rd_valid;
    logic              addr_zero;
    logic [DATA_W-1:0] wb_merged;

    // a stage matches when it writes any lane of the requested register
    assign ex_match  = (|ex_wr_i.wen)  && (ex_wr_i.waddr  == rd_i.raddr);
    assign mem_match = (|mem_wr_i.wen) && (mem_wr_i.waddr == rd_i.raddr);
    assign wb_match  = wb_wr_i.waddr == rd_i.raddr;

    assign addr_zero = rd_i.raddr == '0;
    assign rd_valid  = rd_i.ren && !addr_zero;

    // writeback lanes overlay the stored word
    always_comb begin
        wb_merged = arr_data_i;
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (wb_match && wb_wr_i.wen[b]) begin
                wb_merged[8*b +: 8] = wb_wr_i.wdata[8*b +: 8];
            end
        end
    end

    // mem over writeback without the ex path
    assign raw_operand_o = mem_match ? mem_wr_i.wdata : wb_merged;

    assign operand_o = addr_zero ? '0             :
                       ex_match  ? ex_wr_i.wdata  :
                       raw_operand_o;

    // hits only count for real register reads
    assign ex_hit_o  = rd_valid && ex_match;
    assign mem_hit_o = rd_valid && mem_match;

endmodule

// ==== hdl/gpr_array.sv ====
`timescale 1ns/1ps

module gpr_array
    import regfile_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  wr_port_t          wb_wr_i,
    input  logic [ADDR_W-1:0] raddr1_i,
    input  logic [ADDR_W-1:0] raddr2_i,
    output logic [DATA_W-1:0] arr_data1_o,
    output logic [DATA_W-1:0] arr_data2_o
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // byte lanes written independently from writeback
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wb_wr_i.wen[b]) begin
                    regs[wb_wr_i.waddr][8*b +: 8] <= wb_wr_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // raw asynchronous reads, register 0 masked downstream
    assign arr_data1_o = regs[raddr1_i];
    assign arr_data2_o = regs[raddr2_i];

    // a known address is needed before any lane is committed
    property p_waddr_known;
        @(posedge clk) disable iff (!arst_n_i)
            (|wb_wr_i.wen) |-> !$isunknown(wb_wr_i.waddr);
    endproperty

    a_waddr_known: assert property (p_waddr_known)
        else $error("gpr_array: write with unknown address %h", wb_wr_i.waddr);

endmodule

// ==== hdl/regfile_pkg.sv ====
package regfile_pkg;

    // register file geometry
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 5;
    localparam int NUM_REGS  = 32;
    localparam int NUM_BYTES = DATA_W / 8;

    // one pipeline-stage write, writing when any byte enable is set
    typedef struct packed {
        logic [NUM_BYTES-1:0] wen;
        logic [ADDR_W-1:0]    waddr;
        logic [DATA_W-1:0]    wdata;
    } wr_port_t;

    // one operand read request
    typedef struct packed {
        logic              ren;
        logic [ADDR_W-1:0] raddr;
    } rd_req_t;

endpackage
